//--- cpuConsts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define WORD_WIDTH 16
`define REG_COUNT 4
`define RESET_PC 0
`define BUS_TIMEOUT 16  // wait cycles before a bus error

`endif

//--- isaPkg.sv
`default_nettype none

`include "cpuConsts.svh"

package isaPkg;

    typedef logic [`WORD_WIDTH-1:0] word_t;

    typedef enum logic [3:0] {
        OP_BNE = 4'd0,
        OP_BEQ = 4'd1,
        OP_BGZ = 4'd2,
        OP_BLZ = 4'd3,
        OP_ADI = 4'd4,
        OP_ORI = 4'd5,
        OP_LHI = 4'd6,
        OP_LWD = 4'd7,
        OP_SWD = 4'd8,
        OP_JMP = 4'd9,
        OP_ALU = 4'd15
    } opcode_t;

    // function field of the register-register group
    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } func_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_ORR,
        ALU_NOT,
        ALU_TCP,
        ALU_SHL,
        ALU_SHR,
        ALU_PASS_HIGH,
        ALU_BNE,
        ALU_BEQ,
        ALU_BGZ,
        ALU_BLZ
    } aluOp_t;

endpackage

`default_nettype wire

//--- ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALT
    } state_t;

    // second alu operand
    typedef enum logic [1:0] {
        REG_B,
        IMM,
        ONE
    } srcB_t;

endpackage

`default_nettype wire

//--- memIf.sv
`default_nettype none
`timescale 1ns/1ns

interface memIf
    import isaPkg::*;
();
    logic req;
    logic write;
    word_t addr;
    word_t wdata;
    word_t rdata;
    logic done;   // one-cycle completion pulse
    logic error;  // one-cycle failure pulse

    modport requester (output req, output write, input done, input error);
    modport addresser (output addr, output wdata, input rdata, input done);
    modport servant (
        input req,
        input write,
        input addr,
        input wdata,
        output rdata,
        output done,
        output error
    );
endinterface

`default_nettype wire

//--- alu.sv
`default_nettype none
`timescale 1ns/1ns

module alu
    import isaPkg::*;
(
    input  aluOp_t op,
    input  word_t a,
    input  word_t b,
    output word_t result,
    output logic branchTaken
);
    always_comb
    begin
        result = '0;
        branchTaken = 1'b0;
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_ORR: result = a | b;
            ALU_NOT: result = ~a;
            ALU_TCP: result = ~a + b;  // b is one here
            ALU_SHL: result = a << 1;
            ALU_SHR: result = word_t'($signed(a) >>> 1);
            ALU_PASS_HIGH: result = b << 8;
            ALU_BNE: branchTaken = (a != b);
            ALU_BEQ: branchTaken = (a == b);
            ALU_BGZ: branchTaken = ($signed(a) > 0);
            ALU_BLZ: branchTaken = ($signed(a) < 0);
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- busTimer.sv
`default_nettype none
`timescale 1ns/1ns

`include "cpuConsts.svh"

module busTimer
(
    input  logic clk,
    input  logic reset,
    input  logic waiting,
    output logic expired
);
    localparam int CountWidth = $clog2(`BUS_TIMEOUT + 1);

    logic [CountWidth-1:0] count;

    always_ff @(posedge clk)
    begin
        if (reset || !waiting)
            count <= '0;
        else if (!expired)
            count <= count + 1'b1;  // saturates at the timeout
    end

    assign expired = (count == CountWidth'(`BUS_TIMEOUT));

endmodule

`default_nettype wire

//--- wbMaster.sv
`default_nettype none
`timescale 1ns/1ns

module wbMaster
    import isaPkg::*;
(
    input  logic clk,
    input  logic reset,
    memIf.servant mem,
    output logic wbCyc,
    output logic wbStb,
    output logic wbWe,
    output word_t wbAdr,
    output word_t wbDatO,
    input  word_t wbDatI,
    input  logic wbAck
);
    logic busy;
    logic expired;
    logic start;

    busTimer watchdog (
        .clk(clk),
        .reset(reset),
        .waiting(busy && !wbAck),
        .expired(expired)
    );

    // no restart while the previous completion is still visible
    assign start = !busy && mem.req && !mem.done && !mem.error;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            wbWe <= 1'b0;
            mem.done <= 1'b0;
            mem.error <= 1'b0;
        end
        else
        begin
            mem.done <= 1'b0;
            mem.error <= 1'b0;
            if (start)
            begin
                busy <= 1'b1;
                wbWe <= mem.write;
            end
            else if (busy && wbAck)
            begin
                busy <= 1'b0;
                wbWe <= 1'b0;
                mem.done <= 1'b1;
            end
            else if (busy && expired)
            begin
                busy <= 1'b0;
                wbWe <= 1'b0;
                mem.error <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            wbAdr <= mem.addr;
            wbDatO <= mem.wdata;
        end
        if (busy && wbAck)
            mem.rdata <= wbDatI;
    end

    assign wbCyc = busy;
    assign wbStb = busy;

endmodule

`default_nettype wire

//--- datapath.sv
`default_nettype none
`timescale 1ns/1ns

`include "cpuConsts.svh"

module datapath
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  logic clk,
    input  logic reset,
    memIf.addresser mem,
    input  aluOp_t aluOp,
    input  srcB_t srcB,
    input  logic pcWrite,
    input  logic irWrite,
    input  logic regWrite,
    input  logic mdrWrite,
    input  logic memAddrFromAlu,
    input  logic resultFromMem,
    input  logic outputValid,
    output opcode_t opcode,
    output func_t func,
    output logic branchTaken,
    output word_t outputPort
);
    word_t pc;
    word_t ir;
    word_t mdr;
    word_t aluOut;
    word_t aluResult;
    word_t regFile [`REG_COUNT];
    word_t regA;
    word_t regB;
    word_t opB;
    word_t imm;
    word_t nextPc;
    word_t outReg;
    logic [1:0] rs;
    logic [1:0] rt;
    logic [1:0] rd;
    logic [1:0] dest;

    assign opcode = opcode_t'(ir[15:12]);
    assign func = func_t'(ir[5:0]);
    assign rs = ir[11:10];
    assign rt = ir[9:8];
    assign rd = ir[7:6];
    assign dest = (opcode == OP_ALU) ? rd : rt;
    assign imm = (opcode == OP_ORI) ? {{(`WORD_WIDTH-8){1'b0}}, ir[7:0]}
                                    : {{(`WORD_WIDTH-8){ir[7]}}, ir[7:0]};
    assign regA = regFile[rs];
    assign regB = regFile[rt];

    always_comb
    begin
        case (srcB)
            IMM: opB = imm;
            ONE: opB = word_t'(1);
            default: opB = regB;
        endcase
    end

    alu aluUnit (
        .op(aluOp),
        .a(regA),
        .b(opB),
        .result(aluResult),
        .branchTaken(branchTaken)
    );

    // pc already points past the current instruction after fetch
    assign nextPc = irWrite ? pc + 1'b1
                  : (opcode == OP_JMP) ? {pc[15:12], ir[11:0]}
                  : pc + imm;

    assign mem.addr = memAddrFromAlu ? aluOut : pc;
    assign mem.wdata = regB;
    assign outputPort = outputValid ? regA : outReg;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= word_t'(`RESET_PC);
            ir <= '0;
            outReg <= '0;
            for (int i = 0; i < `REG_COUNT; i++)
                regFile[i] <= '0;
        end
        else
        begin
            if (pcWrite)
                pc <= nextPc;
            if (irWrite && mem.done)
                ir <= mem.rdata;
            if (regWrite)
                regFile[dest] <= resultFromMem ? mdr : aluOut;
            if (outputValid)
                outReg <= regA;
        end
    end

    always_ff @(posedge clk)
    begin
        aluOut <= aluResult;
        if (mdrWrite && mem.done)
            mdr <= mem.rdata;
    end

endmodule

`default_nettype wire

//--- controlUnit.sv
`default_nettype none
`timescale 1ns/1ns

module controlUnit
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  logic clk,
    input  logic reset,
    input  opcode_t opcode,
    input  func_t func,
    input  logic branchTaken,
    memIf.requester mem,
    output aluOp_t aluOp,
    output srcB_t srcB,
    output logic pcWrite,
    output logic irWrite,
    output logic regWrite,
    output logic mdrWrite,
    output logic memAddrFromAlu,
    output logic resultFromMem,
    output logic outputValid,
    output logic halted,
    output logic busError
);
    state_t state;
    state_t nextState;
    logic isAluGroup;
    logic isImm;
    logic isMem;
    logic isBranch;
    logic aluFunc;
    logic writesReg;

    assign isAluGroup = (opcode == OP_ALU);
    assign isImm = (opcode == OP_ADI) || (opcode == OP_ORI) || (opcode == OP_LHI);
    assign isMem = (opcode == OP_LWD) || (opcode == OP_SWD);
    assign isBranch = (opcode == OP_BNE) || (opcode == OP_BEQ)
                   || (opcode == OP_BGZ) || (opcode == OP_BLZ);
    assign writesReg = isImm || (isAluGroup && aluFunc);

    always_comb
    begin
        aluOp = ALU_ADD;  // address add for LWD and SWD
        srcB = IMM;
        aluFunc = 1'b1;
        case (opcode)
            OP_BNE:
            begin
                aluOp = ALU_BNE;
                srcB = REG_B;
            end
            OP_BEQ:
            begin
                aluOp = ALU_BEQ;
                srcB = REG_B;
            end
            OP_BGZ:
            begin
                aluOp = ALU_BGZ;
                srcB = REG_B;
            end
            OP_BLZ:
            begin
                aluOp = ALU_BLZ;
                srcB = REG_B;
            end
            OP_ORI: aluOp = ALU_ORR;
            OP_LHI: aluOp = ALU_PASS_HIGH;
            OP_ALU:
            begin
                srcB = REG_B;
                case (func)
                    FN_ADD: aluOp = ALU_ADD;
                    FN_SUB: aluOp = ALU_SUB;
                    FN_AND: aluOp = ALU_AND;
                    FN_ORR: aluOp = ALU_ORR;
                    FN_NOT: aluOp = ALU_NOT;
                    FN_TCP:
                    begin
                        aluOp = ALU_TCP;
                        srcB = ONE;  // ~a + 1
                    end
                    FN_SHL: aluOp = ALU_SHL;
                    FN_SHR: aluOp = ALU_SHR;
                    default: aluFunc = 1'b0;  // WWD, HLT, unknown
                endcase
            end
            default: ;
        endcase
    end

    always_comb
    begin
        nextState = state;
        case (state)
            FETCH:
                if (mem.done)
                    nextState = DECODE;
            DECODE:
                nextState = (isAluGroup && func == FN_HLT) ? HALT : EXECUTE;
            EXECUTE:
                if (isMem)
                    nextState = MEMORY;
                else if (writesReg)
                    nextState = WRITEBACK;
                else
                    nextState = FETCH;  // branch, jump, WWD, no-op
            MEMORY:
                if (mem.done)
                    nextState = (opcode == OP_LWD) ? WRITEBACK : FETCH;
            WRITEBACK:
                nextState = FETCH;
            default:
                nextState = HALT;
        endcase
        if (mem.error)
            nextState = HALT;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= FETCH;
            busError <= 1'b0;
        end
        else
        begin
            state <= nextState;
            if (mem.error)
                busError <= 1'b1;
        end
    end

    assign mem.req = (state == FETCH) || (state == MEMORY);
    assign mem.write = (state == MEMORY) && (opcode == OP_SWD);
    assign memAddrFromAlu = (state == MEMORY);
    assign irWrite = (state == FETCH);
    assign pcWrite = ((state == FETCH) && mem.done)
                  || ((state == EXECUTE) && ((opcode == OP_JMP) || (isBranch && branchTaken)));
    assign mdrWrite = (state == MEMORY) && (opcode == OP_LWD);
    assign regWrite = (state == WRITEBACK);
    assign resultFromMem = (opcode == OP_LWD);
    assign outputValid = (state == EXECUTE) && isAluGroup && (func == FN_WWD);
    assign halted = (state == HALT);

endmodule

`default_nettype wire

//--- cpuCore.sv
`default_nettype none
`timescale 1ns/1ns

module cpuCore
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  logic clk,
    input  logic reset,
    output logic wbCyc,
    output logic wbStb,
    output logic wbWe,
    output word_t wbAdr,
    output word_t wbDatO,
    input  word_t wbDatI,
    input  logic wbAck,
    output word_t outputPort,
    output logic outputValid,
    output logic halted,
    output logic busError
);
    memIf memBus ();

    opcode_t opcode;
    func_t func;
    aluOp_t aluOp;
    srcB_t srcB;
    logic branchTaken;
    logic pcWrite;
    logic irWrite;
    logic regWrite;
    logic mdrWrite;
    logic memAddrFromAlu;
    logic resultFromMem;

    controlUnit control (
        .clk(clk),
        .reset(reset),
        .opcode(opcode),
        .func(func),
        .branchTaken(branchTaken),
        .mem(memBus.requester),
        .aluOp(aluOp),
        .srcB(srcB),
        .pcWrite(pcWrite),
        .irWrite(irWrite),
        .regWrite(regWrite),
        .mdrWrite(mdrWrite),
        .memAddrFromAlu(memAddrFromAlu),
        .resultFromMem(resultFromMem),
        .outputValid(outputValid),
        .halted(halted),
        .busError(busError)
    );

    datapath path (
        .clk(clk),
        .reset(reset),
        .mem(memBus.addresser),
        .aluOp(aluOp),
        .srcB(srcB),
        .pcWrite(pcWrite),
        .irWrite(irWrite),
        .regWrite(regWrite),
        .mdrWrite(mdrWrite),
        .memAddrFromAlu(memAddrFromAlu),
        .resultFromMem(resultFromMem),
        .outputValid(outputValid),
        .opcode(opcode),
        .func(func),
        .branchTaken(branchTaken),
        .outputPort(outputPort)
    );

    wbMaster bus (
        .clk(clk),
        .reset(reset),
        .mem(memBus.servant),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbDatO(wbDatO),
        .wbDatI(wbDatI),
        .wbAck(wbAck)
    );

endmodule

`default_nettype wire

//--- cpuCore_assert.sv
`default_nettype none
`timescale 1ns/1ns

module cpuCore_assert
    import isaPkg::*;
(
    input logic clk,
    input logic reset,
    input logic wbCyc,
    input logic wbStb,
    input logic wbWe,
    input word_t wbAdr,
    input word_t wbDatO,
    input logic wbAck,
    input logic outputValid,
    input logic halted
);
    stbInsideCyc: assert property (@(posedge clk) disable iff (reset) wbStb |-> wbCyc)
        else $error("wbStb high without wbCyc");

    // request held until the slave answers or the cycle is dropped
    requestStable: assert property (@(posedge clk) disable iff (reset)
        (wbStb && !wbAck) |=> (!wbStb || ($stable(wbAdr) && $stable(wbWe) && $stable(wbDatO))))
        else $error("bus request changed while waiting for wbAck");

    singleOutputPulse: assert property (@(posedge clk) disable iff (reset)
        outputValid |=> !outputValid)
        else $error("outputValid lasted two cycles");

    noCycleWhenHalted: assert property (@(posedge clk) disable iff (reset)
        halted |=> !$rose(wbCyc))
        else $error("bus cycle started while halted");

endmodule

bind cpuCore cpuCore_assert busChecks (
    .clk(clk),
    .reset(reset),
    .wbCyc(wbCyc),
    .wbStb(wbStb),
    .wbWe(wbWe),
    .wbAdr(wbAdr),
    .wbDatO(wbDatO),
    .wbAck(wbAck),
    .outputValid(outputValid),
    .halted(halted)
);

`default_nettype wire

//--- cpuCore_tb.sv
`default_nettype none
`timescale 1ns/1ns

module cpuCore_tb
    import isaPkg::*;
();
    localparam logic [2:0] ModeRandom = 3'd0;
    localparam logic [2:0] ModeEqual = 3'd1;     // b copies a
    localparam logic [2:0] ModePositive = 3'd2;
    localparam logic [2:0] ModeNegative = 3'd3;
    localparam logic [2:0] ModeZero = 3'd4;
    localparam logic [2:0] ModeMemory = 3'd5;    // a is the data area base
    localparam int CaseCount = 23;
    localparam int RunTimeout = 20000;
    localparam int ErrorTimeout = 200;

    typedef struct packed {
        opcode_t opcode;
        func_t func;
        logic wwdAfter;    // low for a branch or jump over a marker
        logic [2:0] mode;
    } testCase_t;

    localparam testCase_t Cases [CaseCount] = '{
        '{OP_ALU, FN_ADD, 1'b1, ModeRandom},
        '{OP_ALU, FN_SUB, 1'b1, ModeRandom},
        '{OP_ALU, FN_AND, 1'b1, ModeRandom},
        '{OP_ALU, FN_ORR, 1'b1, ModeRandom},
        '{OP_ALU, FN_NOT, 1'b1, ModeRandom},
        '{OP_ALU, FN_TCP, 1'b1, ModeRandom},
        '{OP_ALU, FN_SHL, 1'b1, ModeRandom},
        '{OP_ALU, FN_SHR, 1'b1, ModeNegative},
        '{OP_ALU, func_t'(6'd10), 1'b1, ModeRandom},
        '{OP_ADI, FN_ADD, 1'b1, ModeRandom},
        '{OP_ORI, FN_ADD, 1'b1, ModeRandom},
        '{OP_LHI, FN_ADD, 1'b1, ModeRandom},
        '{OP_SWD, FN_ADD, 1'b1, ModeMemory},
        '{OP_BNE, FN_ADD, 1'b0, ModeRandom},
        '{OP_BNE, FN_ADD, 1'b0, ModeEqual},
        '{OP_BEQ, FN_ADD, 1'b0, ModeEqual},
        '{OP_BEQ, FN_ADD, 1'b0, ModeRandom},
        '{OP_BGZ, FN_ADD, 1'b0, ModePositive},
        '{OP_BGZ, FN_ADD, 1'b0, ModeNegative},
        '{OP_BGZ, FN_ADD, 1'b0, ModeZero},
        '{OP_BLZ, FN_ADD, 1'b0, ModeNegative},
        '{OP_BLZ, FN_ADD, 1'b0, ModePositive},
        '{OP_JMP, FN_ADD, 1'b0, ModeRandom}
    };

    logic clk;
    logic reset = 1'b1;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    word_t wbAdr;
    word_t wbDatO;
    word_t wbDatI = '0;
    logic wbAck = 1'b0;
    word_t outputPort;
    logic outputValid;
    logic halted;
    logic busError;

    word_t mem [256];
    word_t expected [$];
    word_t wantAdr [$];
    word_t wantDat [$];
    logic ackEnable = 1'b1;
    int ackDelay = 0;
    int valueErrors = 0;
    int otherErrors = 0;
    int seedValue;

    cpuCore uut (
        .clk(clk),
        .reset(reset),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbDatO(wbDatO),
        .wbDatI(wbDatI),
        .wbAck(wbAck),
        .outputPort(outputPort),
        .outputValid(outputValid),
        .halted(halted),
        .busError(busError)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t encode(opcode_t op, logic [1:0] rs, logic [1:0] rt,
                                     logic [7:0] low);
        return {op, rs, rt, low};
    endfunction

    function automatic word_t encodeWwd(logic [1:0] rs);
        return encode(OP_ALU, rs, 2'd0, {2'd0, FN_WWD});
    endfunction

    function automatic word_t shapeA(logic [2:0] mode, word_t r);
        case (mode)
            ModePositive: return {1'b0, r[14:1], 1'b1};
            ModeNegative: return {1'b1, r[14:0]};
            ModeZero: return '0;
            ModeMemory: return 16'h00E0;
            default: return r;
        endcase
    endfunction

    function automatic word_t aluModel(opcode_t op, func_t fn, word_t a, word_t b,
                                       logic [7:0] imm, word_t keep);
        case (op)
            OP_ADI: return a + {{8{imm[7]}}, imm};
            OP_ORI: return a | {8'h00, imm};
            OP_LHI: return {imm, 8'h00};
            default: ;
        endcase
        case (fn)
            FN_ADD: return a + b;
            FN_SUB: return a - b;
            FN_AND: return a & b;
            FN_ORR: return a | b;
            FN_NOT: return ~a;
            FN_TCP: return 16'd0 - a;
            FN_SHL: return {a[14:0], 1'b0};
            FN_SHR: return {a[15], a[15:1]};
            default: return keep;  // unknown function leaves rd alone
        endcase
    endfunction

    function automatic logic branchModel(opcode_t op, word_t a, word_t b);
        case (op)
            OP_BNE: return a != b;
            OP_BEQ: return a == b;
            OP_BGZ: return !a[15] && (a != 16'd0);
            OP_BLZ: return a[15];
            default: return 1'b1;  // jump
        endcase
    endfunction

    task automatic checkWord(string name, word_t actual, word_t want);
        if (actual !== want)
        begin
            valueErrors++;
            $display("FAILED %0t %s got %h expected %h", $time, name, actual, want);
        end
    endtask

    task automatic checkFlag(string name, logic actual, logic want);
        if (actual !== want)
        begin
            valueErrors++;
            $display("FAILED %0t %s got %b expected %b", $time, name, actual, want);
        end
    endtask

    task automatic finishRun();
        $display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    task automatic abortRun(string why);
        $display("%s", why);
        otherErrors++;
        finishRun();
    endtask

    task automatic waitForHalt(input int limit, output logic timedOut);
        int n;
        n = 0;
        while (!halted && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        timedOut = !halted;
    endtask

    task automatic emitLoad(inout int pc, input logic [1:0] r, input word_t value);
        mem[pc] = encode(OP_LHI, 2'd0, r, value[15:8]);
        mem[pc + 1] = encode(OP_ORI, r, r, value[7:0]);
        pc += 2;
    endtask

    task automatic buildProgram();
        int pc;
        word_t a;
        word_t b;
        word_t r2;
        logic [7:0] imm;
        testCase_t tc;
        pc = 0;
        r2 = '0;
        for (int i = 0; i < 256; i++)
            mem[i] = {8'hA5, 8'(i)};  // opcode 10 runs as a no-op
        for (int i = 0; i < CaseCount; i++)
        begin
            tc = Cases[i];
            a = shapeA(tc.mode, word_t'($urandom));
            b = (tc.mode == ModeEqual) ? a : word_t'($urandom);
            imm = 8'($urandom);
            emitLoad(pc, 2'd0, a);
            emitLoad(pc, 2'd1, b);
            if (tc.opcode == OP_SWD)
            begin
                imm[7:4] = 4'h0;  // stay inside the data area
                mem[pc] = encode(OP_SWD, 2'd0, 2'd1, imm);
                mem[pc + 1] = encode(OP_LWD, 2'd0, 2'd2, imm);
                wantAdr.push_back(a + {8'h00, imm});
                wantDat.push_back(b);
                r2 = b;
                pc += 2;
            end
            else if (tc.wwdAfter)
            begin
                r2 = aluModel(tc.opcode, tc.func, a, b, imm, r2);
                if (tc.opcode == OP_ALU)
                    mem[pc] = encode(OP_ALU, 2'd0, 2'd1, {2'd2, tc.func});
                else
                    mem[pc] = encode(tc.opcode, 2'd0, 2'd2, imm);
                pc += 1;
            end
            else
            begin
                if (tc.opcode == OP_JMP)
                    mem[pc] = {OP_JMP, 12'(pc + 2)};
                else
                    mem[pc] = encode(tc.opcode, 2'd0, 2'd1, 8'd1);  // taken skips one word
                mem[pc + 1] = encodeWwd(2'd0);  // marker
                mem[pc + 2] = encodeWwd(2'd1);
                if (!branchModel(tc.opcode, a, b))
                    expected.push_back(a);
                expected.push_back(b);
                pc += 3;
            end
            if (tc.wwdAfter)
            begin
                mem[pc] = encodeWwd(2'd2);
                expected.push_back(r2);
                pc += 1;
            end
        end
        mem[pc] = encode(OP_ALU, 2'd0, 2'd0, {2'd0, FN_HLT});
    endtask

    // slave with a random ack delay of zero to three cycles
    always @(posedge clk)
    begin
        if (reset || wbAck || !(wbCyc && wbStb))
            wbAck <= 1'b0;
        else if (ackDelay != 0)
            ackDelay = ackDelay - 1;
        else if (ackEnable)
        begin
            wbAck <= 1'b1;
            wbDatI <= mem[wbAdr[7:0]];
            ackDelay = $urandom_range(3, 0);
            if (wbWe)
            begin
                mem[wbAdr[7:0]] = wbDatO;
                if (wantAdr.size() == 0)
                begin
                    otherErrors++;
                    $display("unexpected bus write at %0t", $time);
                end
                else
                begin
                    checkWord("wbAdr", wbAdr, wantAdr.pop_front());
                    checkWord("wbDatO", wbDatO, wantDat.pop_front());
                end
            end
        end
    end

    always @(negedge clk)
    begin
        if (!reset && outputValid)
        begin
            if (expected.size() == 0)
            begin
                otherErrors++;
                $display("outputValid pulsed at %0t with no output expected", $time);
            end
            else
                checkWord("outputPort", outputPort, expected.pop_front());
        end
    end

    initial
    begin
        int n;
        logic timedOut;
        seedValue = $urandom(32'h4e3d6d29);
        buildProgram();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        waitForHalt(RunTimeout, timedOut);
        if (timedOut)
            abortRun("timeout: the core never halted at the end of the program");
        else
        begin
            checkFlag("busError", busError, 1'b0);
            if (expected.size() != 0)
            begin
                otherErrors++;
                $display("%0d expected WWD outputs never appeared", expected.size());
            end
            if (wantAdr.size() != 0)
            begin
                otherErrors++;
                $display("the store never reached the bus");
            end
            for (n = 0; n < 20; n++)
            begin
                @(negedge clk);
                checkFlag("wbCyc", wbCyc, 1'b0);  // idle while halted
            end
            ackEnable = 1'b0;  // slave goes silent
            @(posedge clk);
            reset <= 1'b1;
            repeat (2) @(posedge clk);
            reset <= 1'b0;
            @(negedge clk);
            checkFlag("halted", halted, 1'b0);
            checkFlag("busError", busError, 1'b0);
            waitForHalt(ErrorTimeout, timedOut);
            if (timedOut)
                abortRun("timeout: the core never halted after a missing acknowledge");
            else
            begin
                checkFlag("busError", busError, 1'b1);
                finishRun();
            end
        end
    end

endmodule

`default_nettype wire

//--- cpuCore.f
+incdir+.
isaPkg.sv
ctrlPkg.sv
memIf.sv
alu.sv
busTimer.sv
wbMaster.sv
datapath.sv
controlUnit.sv
cpuCore.sv
cpuCore_assert.sv
cpuCore_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f cpuCore.f --top-module cpuCore_tb \
    --Mdir obj_dir -o cpuCoreSim

./obj_dir/cpuCoreSim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
